// ==== vpu_prod_eu.f ====
+incdir+include
verilog/vpu_prod_pkg.sv
verilog/vpu_prod_fifo.sv
verilog/vpu_prod_agen.sv
verilog/vpu_prod_rq_disp.sv
verilog/vpu_prod_rs_dist.sv
verilog/vpu_prod_mac.sv
verilog/vpu_prod_eu.sv
testbench/tb_vpu_prod_eu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_vpu_prod_eu
FLIST ?= vpu_prod_eu.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/vpu_prod_cases.txt ====
# en0 vl0 rs0 rt0 acc0 exp0 en1 vl1 rs1 rt1 acc1 exp1, all hex
# element e of memory is e * 0x9E37 + 5, exp = acc + sum of products
1 3 0 4 00000000 7E7E8C82 0 0 0 0 00000000 00000000
1 1 1 3 00000010 25642BE8 1 0 0 0 DEADBEEF DEADBEEF
1 2 3 0 00000001 8738780F 1 1 2 2 00000000 872C1BA9
0 0 0 0 00000000 00000000 1 3 1 0 00000000 0E5B4E7E

// ==== testbench/tb_vpu_prod_eu.sv ====
// ******************************
// testbench for the vector dot-product unit
// LSU memory model and case file driver
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module tb_vpu_prod_eu;

localparam int NT = `VPU_NTHREADS;
localparam int NS = `VPU_NSTREAMS;
localparam int TW = $clog2(NT);
localparam int MAXC = 16;

logic clk;
logic nrst;
logic i_start;
logic o_busy;
logic [NT-1:0] i_th_en;
logic [NT-1:0][`VPU_VLEN_W-1:0] i_th_vl;
logic [NT-1:0][`VPU_EADDR_W-1:0] i_th_rs;
logic [NT-1:0][`VPU_EADDR_W-1:0] i_th_rt;
logic [NT-1:0][`VPU_DATA_W-1:0] i_th_acc;
logic i_lsu_rrq_rdy;
logic o_lsu_rrq_wr;
logic [$clog2(NT)-1:0] o_lsu_rrq_th;
logic o_lsu_rrq_arg;
logic [`VPU_WADDR_W-1:0] o_lsu_rrq_addr;
logic i_lsu_rrs_vld;
logic o_lsu_rrs_rd;
logic [$clog2(NT)-1:0] i_lsu_rrs_th;
logic i_lsu_rrs_arg;
logic [63:0] i_lsu_rrs_data;
logic [$clog2(NT)-1:0] o_prod_th;
logic o_prod_wr_en;
logic [`VPU_DATA_W-1:0] o_prod_data;

// cases read from the file
logic [63:0] c_f [MAXC][12];
int ncases;
int limit;
bit limit_set;
int errors;
int checks;
// requests seen per stream, stream = thread * 2 + arg
int req_cnt [NS];
int res_cnt [NT];
logic [31:0] res_val [NT];
// pending LSU reads as {th, arg, word address}
logic [TW+`VPU_WADDR_W:0] rq_q [$];
bit rsp_taken;

vpu_prod_eu uut (.*);

initial
begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

function automatic logic [31:0] elem(input logic [`VPU_EADDR_W-1:0] e);
	return 32'(e * 32'h9E37 + 32'd5);
endfunction

// words touched by a vector of n elements from element a
function automatic int words_spanned(input logic [63:0] a, input logic [63:0] n);
	if (n == 0)
		return 0;
	return int'(((a + n - 1) >> 1) - (a >> 1) + 1);
endfunction

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

// LSU request capture, response acceptance and result pulses
always @(posedge clk)
begin
	if (nrst)
	begin
		if (o_lsu_rrq_wr)
		begin
			check("o_lsu_rrq_wr with i_lsu_rrq_rdy", i_lsu_rrq_rdy, 1);
			rq_q.push_back({o_lsu_rrq_th, o_lsu_rrq_arg, o_lsu_rrq_addr});
			req_cnt[{o_lsu_rrq_th, o_lsu_rrq_arg}]++;
		end
		if (i_lsu_rrs_vld && o_lsu_rrs_rd)
			rsp_taken = 1'b1;
		if (o_prod_wr_en)
		begin
			res_cnt[o_prod_th]++;
			res_val[o_prod_th] = o_prod_data;
		end
	end
end

// LSU answers in request order after a random delay
always @(negedge clk)
begin
	logic [TW+`VPU_WADDR_W:0] r;
	if (rsp_taken)
	begin
		void'(rq_q.pop_front());
		i_lsu_rrs_vld = 1'b0;
		rsp_taken = 1'b0;
	end
	if (!i_lsu_rrs_vld && rq_q.size() > 0 && ($urandom % 3) == 0)
	begin
		r = rq_q[0];
		i_lsu_rrs_th = r[TW+`VPU_WADDR_W:`VPU_WADDR_W+1];
		i_lsu_rrs_arg = r[`VPU_WADDR_W];
		i_lsu_rrs_data = {elem({r[`VPU_WADDR_W-1:0], 1'b1}),
			elem({r[`VPU_WADDR_W-1:0], 1'b0})};
		i_lsu_rrs_vld = 1'b1;
	end
	if (nrst)
		i_lsu_rrq_rdy = ($urandom % 4) != 0;
end

task automatic read_cases();
	int fd;
	int n;
	string line;
	logic [63:0] f [12];
	fd = $fopen("testbench/vpu_prod_cases.txt", "r");
	if (fd == 0)
	begin
		$display("could not open the cases file");
		errors++;
		return;
	end
	while (!$feof(fd) && ncases < MAXC)
	begin
		line = "";
		void'($fgets(line, fd));
		if (line.len() == 0 || line[0] == "#")
			continue;
		n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
			f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
		if (n != 12)
			continue;
		for (int k = 0; k < 12; k++)
			c_f[ncases][k] = f[k];
		ncases++;
	end
	$fclose(fd);
endtask

task automatic run_case(input int c);
	int exp_req [NS];
	string nm;
	for (int s = 0; s < NS; s++)
	begin
		req_cnt[s] = 0;
		exp_req[s] = 0;
	end
	for (int t = 0; t < NT; t++)
	begin
		res_cnt[t] = 0;
		res_val[t] = '0;
	end
	@(negedge clk);
	for (int t = 0; t < NT; t++)
	begin
		// six columns per thread
		i_th_en[t] = c_f[c][t*6][0];
		i_th_vl[t] = c_f[c][t*6+1][`VPU_VLEN_W-1:0];
		i_th_rs[t] = c_f[c][t*6+2][`VPU_EADDR_W-1:0];
		i_th_rt[t] = c_f[c][t*6+3][`VPU_EADDR_W-1:0];
		i_th_acc[t] = c_f[c][t*6+4][31:0];
		if (c_f[c][t*6][0])
		begin
			exp_req[2*t] = words_spanned(c_f[c][t*6+2], c_f[c][t*6+1]);
			exp_req[2*t+1] = words_spanned(c_f[c][t*6+3], c_f[c][t*6+1]);
		end
	end
	i_start = 1'b1;
	@(negedge clk);
	i_start = 1'b0;
	check("o_busy after i_start", o_busy, 1);
	while (o_busy)
		@(negedge clk);
	// results must all be out once busy drops
	for (int t = 0; t < NT; t++)
	begin
		nm = $sformatf("case %0d o_prod_wr_en count th%0d", c, t);
		check(nm, res_cnt[t], c_f[c][t*6][0] ? 1 : 0);
		if (c_f[c][t*6][0])
		begin
			nm = $sformatf("case %0d o_prod_data th%0d", c, t);
			check(nm, res_val[t], c_f[c][t*6+5][31:0]);
		end
	end
	for (int s = 0; s < NS; s++)
	begin
		nm = $sformatf("case %0d o_lsu_rrq_wr count stream %0d", c, s);
		check(nm, req_cnt[s], exp_req[s]);
	end
	repeat (3)
	begin
		@(negedge clk);
		check("o_busy idle", o_busy, 0);
		check("o_prod_wr_en idle", o_prod_wr_en, 0);
	end
endtask

initial
begin
	wait (limit_set);
	repeat (limit) @(posedge clk);
	$display("timeout, the unit did not finish all cases in %0d cycles", limit);
	$display("Verification failed");
	$finish;
end

initial
begin
	int total;
	nrst = 1'b0;
	i_start = 1'b0;
	i_th_en = '0;
	i_th_vl = '0;
	i_th_rs = '0;
	i_th_rt = '0;
	i_th_acc = '0;
	i_lsu_rrq_rdy = 1'b0;
	i_lsu_rrs_vld = 1'b0;
	i_lsu_rrs_th = '0;
	i_lsu_rrs_arg = 1'b0;
	i_lsu_rrs_data = '0;
	errors = 0;
	checks = 0;
	ncases = 0;
	total = 0;
	void'($urandom(32'h5211_0fd1));
	read_cases();
	for (int c = 0; c < ncases; c++)
		total += int'(c_f[c][1] + c_f[c][7]);
	limit = total * 40 + 200;
	limit_set = 1'b1;
	repeat (8) @(posedge clk);
	@(negedge clk);
	nrst = 1'b1;
	@(negedge clk);
	check("o_busy after reset", o_busy, 0);
	check("o_lsu_rrq_wr after reset", o_lsu_rrq_wr, 0);
	check("o_lsu_rrs_rd after reset", o_lsu_rrs_rd, 0);
	check("o_prod_wr_en after reset", o_prod_wr_en, 0);
	if (ncases == 0)
	begin
		$display("no cases were read");
		errors++;
	end
	for (int c = 0; c < ncases; c++)
		run_case(c);
	$display("cases: %0d, checks: %0d, errors: %0d", ncases, checks, errors);
	if (errors == 0)
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

endmodule

// ==== verilog/vpu_prod_eu.sv ====
// ******************************
// vector dot-product execution unit
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module vpu_prod_eu
(
	input  logic                                        clk,
	input  logic                                        nrst,
	input  logic                                        i_start,
	output logic                                        o_busy,
	input  logic [`VPU_NTHREADS-1:0]                    i_th_en,
	input  logic [`VPU_NTHREADS-1:0][`VPU_VLEN_W-1:0]   i_th_vl,
	input  logic [`VPU_NTHREADS-1:0][`VPU_EADDR_W-1:0]  i_th_rs,
	input  logic [`VPU_NTHREADS-1:0][`VPU_EADDR_W-1:0]  i_th_rt,
	input  logic [`VPU_NTHREADS-1:0][`VPU_DATA_W-1:0]   i_th_acc,
	input  logic                                        i_lsu_rrq_rdy,
	output logic                                        o_lsu_rrq_wr,
	output logic [$clog2(`VPU_NTHREADS)-1:0]            o_lsu_rrq_th,
	output logic                                        o_lsu_rrq_arg,
	output logic [`VPU_WADDR_W-1:0]                     o_lsu_rrq_addr,
	input  logic                                        i_lsu_rrs_vld,
	output logic                                        o_lsu_rrs_rd,
	input  logic [$clog2(`VPU_NTHREADS)-1:0]            i_lsu_rrs_th,
	input  logic                                        i_lsu_rrs_arg,
	input  logic [2*`VPU_DATA_W-1:0]                    i_lsu_rrs_data,
	output logic [$clog2(`VPU_NTHREADS)-1:0]            o_prod_th,
	output logic                                        o_prod_wr_en,
	output logic [`VPU_DATA_W-1:0]                      o_prod_data
);

localparam int NS = `VPU_NSTREAMS;

logic [NS-1:0]                   ag_valid;
logic [NS-1:0]                   ag_incr;
logic [NS-1:0][`VPU_WADDR_W-1:0] ag_addr;
logic [NS-1:0][1:0]              ag_mask;
// mask FIFO side
logic [NS-1:0]                   we_wr;
logic [NS-1:0]                   we_rdy;
logic [NS-1:0]                   we_rd;
logic [NS-1:0]                   we_vld;
logic [1:0]                      we_in;
logic [NS-1:0][1:0]              we_out;
// operand FIFO side
logic [NS-1:0]                   op_wr;
logic [NS-1:0]                   op_rdy;
logic [NS-1:0]                   op_rd;
logic [NS-1:0]                   op_vld;
logic [`VPU_DATA_W-1:0]          op_in;
logic [NS-1:0][`VPU_DATA_W-1:0]  op_out;
logic                            busy_q;
logic                            disp_busy;
logic                            dist_busy;
logic                            mac_busy;

// covers the cycle before the units see the start
always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
		busy_q <= 1'b0;
	else
		busy_q <= i_start;
end

assign o_busy = busy_q | disp_busy | dist_busy | mac_busy;

for (genvar t = 0; t < `VPU_NTHREADS; t++)
begin : g_th
	for (genvar a = 0; a < 2; a++)
	begin : g_arg
		localparam int S = t * 2 + a;

		vpu_prod_agen #(
			.ARG(vpu_prod_pkg::arg_e'(a))
		) u_agen (
			.clk(clk),
			.nrst(nrst),
			.i_latch(i_start & i_th_en[t]),
			.i_vaddr((a == 1) ? i_th_rt[t] : i_th_rs[t]),
			.i_vlen(i_th_vl[t]),
			.i_incr(ag_incr[S]),
			.o_valid(ag_valid[S]),
			.o_addr(ag_addr[S]),
			.o_we_mask(ag_mask[S])
		);

		vpu_prod_fifo #(
			.DATA_W(2),
			.DEPTH_POW2(`VPU_FIFO_DEPTH_POW2)
		) u_we_fifo (
			.clk(clk),
			.nrst(nrst),
			.i_wr(we_wr[S]),
			.i_data(we_in),
			.o_rdy(we_rdy[S]),
			.i_rd(we_rd[S]),
			.o_data(we_out[S]),
			.o_vld(we_vld[S])
		);

		vpu_prod_fifo #(
			.DATA_W(`VPU_DATA_W),
			.DEPTH_POW2(`VPU_FIFO_DEPTH_POW2)
		) u_op_fifo (
			.clk(clk),
			.nrst(nrst),
			.i_wr(op_wr[S]),
			.i_data(op_in),
			.o_rdy(op_rdy[S]),
			.i_rd(op_rd[S]),
			.o_data(op_out[S]),
			.o_vld(op_vld[S])
		);
	end
end

vpu_prod_rq_disp u_rq_disp (
	.clk(clk),
	.nrst(nrst),
	.i_ag_valid(ag_valid),
	.i_ag_addr(ag_addr),
	.i_ag_mask(ag_mask),
	.i_we_rdy(we_rdy),
	.i_lsu_rrq_rdy(i_lsu_rrq_rdy),
	.o_ag_incr(ag_incr),
	.o_we_wr(we_wr),
	.o_we_mask(we_in),
	.o_lsu_rrq_wr(o_lsu_rrq_wr),
	.o_lsu_rrq_th(o_lsu_rrq_th),
	.o_lsu_rrq_arg(o_lsu_rrq_arg),
	.o_lsu_rrq_addr(o_lsu_rrq_addr),
	.o_busy(disp_busy)
);

vpu_prod_rs_dist u_rs_dist (
	.clk(clk),
	.nrst(nrst),
	.i_lsu_rrs_vld(i_lsu_rrs_vld),
	.i_lsu_rrs_th(i_lsu_rrs_th),
	.i_lsu_rrs_arg(vpu_prod_pkg::arg_e'(i_lsu_rrs_arg)),
	.i_lsu_rrs_data(i_lsu_rrs_data),
	.i_we_mask(we_out),
	.i_we_vld(we_vld),
	.i_op_rdy(op_rdy),
	.o_lsu_rrs_rd(o_lsu_rrs_rd),
	.o_we_rd(we_rd),
	.o_op_wr(op_wr),
	.o_op_data(op_in),
	.o_busy(dist_busy)
);

vpu_prod_mac u_mac (
	.clk(clk),
	.nrst(nrst),
	.i_start(i_start),
	.i_th_en(i_th_en),
	.i_th_vl(i_th_vl),
	.i_th_acc(i_th_acc),
	.i_op_data(op_out),
	.i_op_vld(op_vld),
	.o_op_rd(op_rd),
	.o_prod_th(o_prod_th),
	.o_prod_wr_en(o_prod_wr_en),
	.o_prod_data(o_prod_data),
	.o_busy(mac_busy)
);

endmodule

// ==== verilog/vpu_prod_mac.sv ====
// ******************************
// per-thread multiply-accumulate scheduler
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module vpu_prod_mac
(
	input  logic                                        clk,
	input  logic                                        nrst,
	input  logic                                        i_start,
	input  logic [`VPU_NTHREADS-1:0]                    i_th_en,
	input  logic [`VPU_NTHREADS-1:0][`VPU_VLEN_W-1:0]   i_th_vl,
	input  logic [`VPU_NTHREADS-1:0][`VPU_DATA_W-1:0]   i_th_acc,
	input  logic [`VPU_NSTREAMS-1:0][`VPU_DATA_W-1:0]   i_op_data,
	input  logic [`VPU_NSTREAMS-1:0]                    i_op_vld,
	output logic [`VPU_NSTREAMS-1:0]                    o_op_rd,
	output logic [$clog2(`VPU_NTHREADS)-1:0]            o_prod_th,
	output logic                                        o_prod_wr_en,
	output logic [`VPU_DATA_W-1:0]                      o_prod_data,
	output logic                                        o_busy
);

localparam int NT = `VPU_NTHREADS;
localparam int TH_W = $clog2(`VPU_NTHREADS);

vpu_prod_pkg::mac_state_e state;

logic [NT-1:0]                  pend;
logic [NT-1:0][`VPU_VLEN_W-1:0] cnt;
logic [NT-1:0][`VPU_DATA_W-1:0] acc;
logic [NT-1:0]                  cand;
logic [TH_W-1:0]                rr_ptr;
logic [TH_W-1:0]                sel;
logic [TH_W-1:0]                wr_th;
logic                           found;
logic                           do_mac;

// a thread can go when both heads are there, or at once for zero length
always_comb
begin
	for (int t = 0; t < NT; t++)
		cand[t] = pend[t] & ((cnt[t] == '0) | (i_op_vld[2*t] & i_op_vld[2*t+1]));
end

always_comb
begin
	int idx;
	found = 1'b0;
	sel = rr_ptr;
	for (int k = 0; k < NT; k++)
	begin
		idx = (int'(rr_ptr) + k) % NT;
		if (!found && cand[idx])
		begin
			found = 1'b1;
			sel = TH_W'(idx);
		end
	end
end

assign do_mac = (state == vpu_prod_pkg::MAC_RUN) & found & (cnt[sel] != '0);

always_comb
begin
	for (int t = 0; t < NT; t++)
	begin
		o_op_rd[2*t] = do_mac & (sel == TH_W'(t));
		o_op_rd[2*t+1] = do_mac & (sel == TH_W'(t));
	end
end

assign o_prod_wr_en = (state == vpu_prod_pkg::MAC_WRITE);
assign o_prod_th = wr_th;
assign o_prod_data = acc[wr_th];
assign o_busy = (state != vpu_prod_pkg::MAC_IDLE);

always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		state <= vpu_prod_pkg::MAC_IDLE;
		pend <= '0;
		rr_ptr <= '0;
		wr_th <= '0;
	end
	else
	begin
		case (state)
		vpu_prod_pkg::MAC_IDLE:
			if (i_start)
			begin
				pend <= i_th_en;
				state <= vpu_prod_pkg::MAC_RUN;
			end
		vpu_prod_pkg::MAC_RUN:
			if (pend == '0)
				state <= vpu_prod_pkg::MAC_IDLE;
			else if (found)
			begin
				rr_ptr <= (sel == TH_W'(NT - 1)) ? '0 : sel + 1'b1;
				// last product or empty vector, result goes out next cycle
				if (cnt[sel] <= `VPU_VLEN_W'(1))
				begin
					wr_th <= sel;
					state <= vpu_prod_pkg::MAC_WRITE;
				end
			end
		vpu_prod_pkg::MAC_WRITE:
		begin
			pend[wr_th] <= 1'b0;
			if ((pend & ~(NT'(1) << wr_th)) != '0)
				state <= vpu_prod_pkg::MAC_RUN;
			else
				state <= vpu_prod_pkg::MAC_IDLE;
		end
		default:
			state <= vpu_prod_pkg::MAC_IDLE;
		endcase
	end
end

// sum wraps to the element width
always_ff @(posedge clk)
begin
	if (state == vpu_prod_pkg::MAC_IDLE && i_start)
	begin
		cnt <= i_th_vl;
		acc <= i_th_acc;
	end
	else if (do_mac)
	begin
		cnt[sel] <= cnt[sel] - 1'b1;
		acc[sel] <= acc[sel] + i_op_data[{sel, 1'b0}] * i_op_data[{sel, 1'b1}];
	end
end

endmodule

// ==== verilog/vpu_prod_rs_dist.sv ====
// ******************************
// splits LSU read words into operand elements
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module vpu_prod_rs_dist
(
	input  logic                                   clk,
	input  logic                                   nrst,
	input  logic                                   i_lsu_rrs_vld,
	input  logic [$clog2(`VPU_NTHREADS)-1:0]       i_lsu_rrs_th,
	input  vpu_prod_pkg::arg_e                     i_lsu_rrs_arg,
	input  logic [2*`VPU_DATA_W-1:0]               i_lsu_rrs_data,
	input  logic [`VPU_NSTREAMS-1:0][1:0]          i_we_mask,
	input  logic [`VPU_NSTREAMS-1:0]               i_we_vld,
	input  logic [`VPU_NSTREAMS-1:0]               i_op_rdy,
	output logic                                   o_lsu_rrs_rd,
	output logic [`VPU_NSTREAMS-1:0]               o_we_rd,
	output logic [`VPU_NSTREAMS-1:0]               o_op_wr,
	output logic [`VPU_DATA_W-1:0]                 o_op_data,
	output logic                                   o_busy
);

localparam int NS = `VPU_NSTREAMS;
localparam int SW = $clog2(`VPU_NTHREADS) + 1;
localparam int DW = `VPU_DATA_W;

logic [SW-1:0] strm;
logic [1:0]    mask;
logic          wr_en;
logic          last;
// low half of a two-element word already written
logic          half_q;

assign strm = {i_lsu_rrs_th, i_lsu_rrs_arg == vpu_prod_pkg::ARG_RT};

// elements of the head word still to be written
assign mask = half_q ? 2'b10 : i_we_mask[strm];
assign last = !(mask[0] & mask[1]);
assign wr_en = i_lsu_rrs_vld & i_we_vld[strm] & i_op_rdy[strm];

assign o_op_data = mask[0] ? i_lsu_rrs_data[DW-1:0] : i_lsu_rrs_data[2*DW-1:DW];
assign o_op_wr = wr_en ? (NS'(1) << strm) : '0;

// word and its mask retire together after the last element
assign o_lsu_rrs_rd = wr_en & last;
assign o_we_rd = (wr_en & last) ? (NS'(1) << strm) : '0;
assign o_busy = half_q;

always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
		half_q <= 1'b0;
	else if (wr_en)
		half_q <= !last;
end

// LSU may only answer requests that were issued, each leaves a mask behind
a_rsp_has_mask: assert property (@(posedge clk) disable iff (!nrst)
	i_lsu_rrs_vld |-> i_we_vld[strm])
	else $error("response for stream %0d without a pending request", strm);

endmodule

// ==== verilog/vpu_prod_rq_disp.sv ====
// ******************************
// round-robin dispatcher of word reads to the LSU
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module vpu_prod_rq_disp
(
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic [`VPU_NSTREAMS-1:0]                     i_ag_valid,
	input  logic [`VPU_NSTREAMS-1:0][`VPU_WADDR_W-1:0]   i_ag_addr,
	input  logic [`VPU_NSTREAMS-1:0][1:0]                i_ag_mask,
	input  logic [`VPU_NSTREAMS-1:0]                     i_we_rdy,
	input  logic                                         i_lsu_rrq_rdy,
	output logic [`VPU_NSTREAMS-1:0]                     o_ag_incr,
	output logic [`VPU_NSTREAMS-1:0]                     o_we_wr,
	output logic [1:0]                                   o_we_mask,
	output logic                                         o_lsu_rrq_wr,
	output logic [$clog2(`VPU_NTHREADS)-1:0]             o_lsu_rrq_th,
	output vpu_prod_pkg::arg_e                           o_lsu_rrq_arg,
	output logic [`VPU_WADDR_W-1:0]                      o_lsu_rrq_addr,
	output logic                                         o_busy
);

localparam int NS = `VPU_NSTREAMS;
localparam int SW = $clog2(`VPU_NTHREADS) + 1;

logic [SW-1:0] rr_ptr;
logic [SW-1:0] sel;
logic          found;
logic          xfer;

// first stream at or after the pointer with a word to fetch and mask room
always_comb
begin
	int idx;
	found = 1'b0;
	sel = rr_ptr;
	for (int k = 0; k < NS; k++)
	begin
		idx = (int'(rr_ptr) + k) % NS;
		if (!found && i_ag_valid[idx] && i_we_rdy[idx])
		begin
			found = 1'b1;
			sel = SW'(idx);
		end
	end
end

assign xfer = found & i_lsu_rrq_rdy;

assign o_lsu_rrq_wr = xfer;
assign o_lsu_rrq_th = sel[SW-1:1];
assign o_lsu_rrq_arg = vpu_prod_pkg::arg_e'(sel[0]);
assign o_lsu_rrq_addr = i_ag_addr[sel];
assign o_we_mask = i_ag_mask[sel];
assign o_ag_incr = xfer ? (NS'(1) << sel) : '0;
assign o_we_wr = xfer ? (NS'(1) << sel) : '0;
assign o_busy = |i_ag_valid;

// pointer moves past the stream just served
always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
		rr_ptr <= '0;
	else if (xfer)
		rr_ptr <= (sel == SW'(NS - 1)) ? '0 : sel + 1'b1;
end

endmodule

// ==== verilog/vpu_prod_agen.sv ====
// ******************************
// vector address generator for one stream
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module vpu_prod_agen #(
	parameter vpu_prod_pkg::arg_e ARG = vpu_prod_pkg::ARG_RS
)
(
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   i_latch,
	input  logic [`VPU_EADDR_W-1:0] i_vaddr,
	input  logic [`VPU_VLEN_W-1:0]  i_vlen,
	input  logic                   i_incr,
	output logic                   o_valid,
	output logic [`VPU_WADDR_W-1:0] o_addr,
	output logic [1:0]             o_we_mask
);

logic [`VPU_VLEN_W-1:0] rem;
// current word starts at an odd element
logic                   odd;
logic [`VPU_VLEN_W-1:0] used;

// low half only if the vector covers it, high half if an element remains
assign o_we_mask[0] = !odd;
assign o_we_mask[1] = odd | (rem >= `VPU_VLEN_W'(2));
assign used = o_we_mask[0] && o_we_mask[1] ? `VPU_VLEN_W'(2) : `VPU_VLEN_W'(1);

always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		o_valid <= 1'b0;
		odd <= 1'b0;
		rem <= '0;
	end
	else if (i_latch)
	begin
		o_valid <= (i_vlen != '0);
		odd <= i_vaddr[0];
		rem <= i_vlen;
	end
	else if (i_incr)
	begin
		odd <= 1'b0;
		rem <= rem - used;
		if (rem == used)
			o_valid <= 1'b0;
	end
end

always_ff @(posedge clk)
begin
	if (i_latch)
		o_addr <= i_vaddr[`VPU_EADDR_W-1:1];
	else if (i_incr)
		o_addr <= o_addr + 1'b1;
end

a_incr_valid: assert property (@(posedge clk) disable iff (!nrst) i_incr |-> o_valid)
	else $error("agen %s stepped while idle",
		(ARG == vpu_prod_pkg::ARG_RT) ? "rt" : "rs");

endmodule

// ==== verilog/vpu_prod_fifo.sv ====
// ******************************
// synchronous FIFO, first word visible on o_data
// ******************************
`timescale 1ns/1ps
`include "vpu_prod_settings.svh"

module vpu_prod_fifo #(
	parameter int DATA_W = `VPU_DATA_W,
	parameter int DEPTH_POW2 = `VPU_FIFO_DEPTH_POW2
)
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_wr,
	input  logic [DATA_W-1:0] i_data,
	output logic              o_rdy,
	input  logic              i_rd,
	output logic [DATA_W-1:0] o_data,
	output logic              o_vld
);

localparam int DEPTH = 1 << DEPTH_POW2;

logic [DATA_W-1:0]   mem [DEPTH];
logic [DEPTH_POW2-1:0] wr_ptr;
logic [DEPTH_POW2-1:0] rd_ptr;
logic [DEPTH_POW2:0]   count;
logic                  push;
logic                  pop;

assign push = i_wr & o_rdy;
assign pop = i_rd & o_vld;
assign o_rdy = (count != (DEPTH_POW2+1)'(DEPTH));
assign o_vld = (count != '0);
assign o_data = mem[rd_ptr];

always_ff @(posedge clk or negedge nrst)
begin
	if (!nrst)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end
	else
	begin
		if (push)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		// simultaneous push and pop keeps the count
		if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (push)
		mem[wr_ptr] <= i_data;
end

a_no_overflow: assert property (@(posedge clk) disable iff (!nrst) i_wr |-> o_rdy)
	else $error("fifo written while full");
a_no_underflow: assert property (@(posedge clk) disable iff (!nrst) i_rd |-> o_vld)
	else $error("fifo read while empty");

endmodule

// ==== verilog/vpu_prod_pkg.sv ====
// ******************************
// vpu product unit types
// ******************************
package vpu_prod_pkg;

// vector argument of a request or response
typedef enum logic [0:0]
{
	ARG_RS = 1'b0,
	ARG_RT = 1'b1
} arg_e;

// multiply-accumulate scheduler states
typedef enum logic [1:0]
{
	MAC_IDLE  = 2'd0,
	MAC_RUN   = 2'd1,
	MAC_WRITE = 2'd2
} mac_state_e;

endpackage

// ==== include/vpu_prod_settings.svh ====
// ******************************
// vpu product unit settings
// thread count, widths and FIFO depth
// ******************************
`ifndef VPU_PROD_SETTINGS_SVH
`define VPU_PROD_SETTINGS_SVH

// hardware threads
`define VPU_NTHREADS 2
// two argument streams per thread, stream = thread * 2 + arg
`define VPU_NSTREAMS (2 * `VPU_NTHREADS)

// element and 64-bit word addresses
`define VPU_EADDR_W 38
`define VPU_WADDR_W 37
`define VPU_VLEN_W 20
`define VPU_DATA_W 32

// log2 of the depth of every internal FIFO
`define VPU_FIFO_DEPTH_POW2 2

`endif
